// ==== rtl/vr_pkg.sv ====
package vr_pkg;

    typedef logic [15:0] view_num_t;
    typedef logic [15:0] op_num_t;
    typedef logic [3:0]  replica_id_t;

    // Code 3 is unused and gets dropped by the state stage.
    typedef enum logic [1:0] {
        SETUP   = 2'd0,
        PREPARE = 2'd1,
        COMMIT  = 2'd2
    } vr_msg_type_e;

    typedef enum logic {
        SETUP_ACK  = 1'b0,
        PREPARE_OK = 1'b1
    } vr_reply_type_e;

    typedef struct packed {
        vr_msg_type_e msg_type;
        view_num_t    view;
        op_num_t      op_num;
        op_num_t      commit_num;
        replica_id_t  replica_id;
    } vr_msg_t;

    typedef struct packed {
        vr_reply_type_e reply_type;
        view_num_t      view;
        op_num_t        op_num;
        replica_id_t    replica_id;
        logic           check_log;
    } vr_action_t;

    typedef struct packed {
        view_num_t view;
        op_num_t   op_num;
    } log_hdr_t;

    typedef struct packed {
        vr_reply_type_e reply_type;
        view_num_t      view;
        op_num_t        op_num;
        replica_id_t    replica_id;
    } vr_reply_t;

    typedef struct packed {
        view_num_t view;
        op_num_t   commit_num;
    } vr_status_t;

endpackage

// ==== rtl/vr_log_hdr_mem.sv ====
`timescale 1ns/1ps

module vr_log_hdr_mem
    import vr_pkg::*;
#(
    parameter int LOG_DEPTH = 16,
    localparam int IDX_W = $clog2(LOG_DEPTH)
) (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_addr,
    input  log_hdr_t         wr_data,
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_addr,
    output log_hdr_t         rd_data
);

    log_hdr_t mem [LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds until the next read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/vr_replica_state.sv ====
`timescale 1ns/1ps

module vr_replica_state
    import vr_pkg::*;
#(
    parameter int LOG_DEPTH = 16,
    localparam int IDX_W = $clog2(LOG_DEPTH)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             msg_val,
    input  vr_msg_t          msg,
    output logic             msg_rdy,
    output logic             act_val,
    output vr_action_t       act,
    input  logic             act_rdy,
    output logic             log_wr_en,
    output logic [IDX_W-1:0] log_wr_addr,
    output log_hdr_t         log_wr_data,
    output logic             log_rd_en,
    output logic [IDX_W-1:0] log_rd_addr,
    output vr_status_t       status
);

    view_num_t   view_r;
    op_num_t     last_op_r;
    op_num_t     commit_num_r;
    replica_id_t replica_id_r;

    logic        accept;
    logic        is_setup;
    logic        same_view;
    logic        prep_cur;
    logic        op_nonzero;
    logic        do_append;
    logic        do_retx;
    logic        upd_commit;
    logic        make_act;
    op_num_t     op_behind;
    op_num_t     last_op_new;
    op_num_t     commit_cand;
    vr_action_t  act_next;

    assign msg_rdy = !act_val || act_rdy;
    assign accept  = msg_val && msg_rdy;

    assign is_setup   = msg.msg_type == SETUP;
    assign same_view  = msg.view == view_r;
    assign prep_cur   = (msg.msg_type == PREPARE) && same_view;
    assign op_nonzero = msg.op_num != '0;
    assign op_behind  = last_op_r - msg.op_num;

    assign do_append = prep_cur && op_nonzero && (msg.op_num == last_op_r + 16'd1);

    // Retransmission must still sit inside the log window.
    assign do_retx = prep_cur && op_nonzero && (msg.op_num <= last_op_r)
                     && (op_behind <= op_num_t'(LOG_DEPTH - 1));

    assign upd_commit = same_view
                        && ((msg.msg_type == PREPARE) || (msg.msg_type == COMMIT));

    assign last_op_new = (is_setup || do_append) ? msg.op_num : last_op_r;
    assign commit_cand = (msg.commit_num < last_op_new) ? msg.commit_num : last_op_new;
    assign make_act    = is_setup || do_append || do_retx;

    always_comb begin
        act_next.reply_type = PREPARE_OK;
        act_next.view       = msg.view;
        act_next.op_num     = msg.op_num;
        act_next.replica_id = replica_id_r;
        act_next.check_log  = do_retx;
        if (is_setup) begin
            act_next.reply_type = SETUP_ACK;
            act_next.replica_id = msg.replica_id;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            view_r       <= '0;
            last_op_r    <= '0;
            commit_num_r <= '0;
            replica_id_r <= '0;
        end else if (accept) begin
            last_op_r <= last_op_new;
            if (is_setup) begin
                view_r       <= msg.view;
                replica_id_r <= msg.replica_id;
                commit_num_r <= commit_cand;
            end else if (upd_commit && (commit_cand > commit_num_r)) begin
                commit_num_r <= commit_cand;
            end
        end
    end

    // Slot is free or drains this cycle whenever msg_rdy is high.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_val <= 1'b0;
        end else if (msg_rdy) begin
            act_val <= accept && make_act;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && make_act) begin
            act <= act_next;
        end
    end

    assign log_wr_en          = accept && do_append;
    assign log_wr_addr        = msg.op_num[IDX_W-1:0];
    assign log_wr_data.view   = msg.view;
    assign log_wr_data.op_num = msg.op_num;

    // Read goes out as the check moves into the reply stage.
    assign log_rd_en   = act_val && act_rdy && act.check_log;
    assign log_rd_addr = act.op_num[IDX_W-1:0];

    assign status.view       = view_r;
    assign status.commit_num = commit_num_r;

    commit_le_last_op: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_num_r <= last_op_r
    );

    act_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        act_val && !act_rdy |=> act_val && $stable(act)
    );

endmodule

// ==== rtl/vr_reply_gen.sv ====
`timescale 1ns/1ps

module vr_reply_gen
    import vr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       act_val,
    input  vr_action_t act,
    output logic       act_rdy,
    input  log_hdr_t   log_rd_data,
    output logic       reply_val,
    output vr_reply_t  reply,
    input  logic       reply_rdy
);

    typedef enum logic [1:0] {
        S_EMPTY,
        S_CHECK,
        S_REPLY
    } gen_state_e;

    gen_state_e state;
    logic       load;
    logic       log_match;

    assign act_rdy = (state == S_EMPTY) || ((state == S_REPLY) && reply_rdy);
    assign load    = act_val && act_rdy;

    // Log entry must still belong to the same view and op.
    assign log_match = (log_rd_data.view == reply.view)
                       && (log_rd_data.op_num == reply.op_num);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_EMPTY;
        end else if (load) begin
            state <= act.check_log ? S_CHECK : S_REPLY;
        end else if (state == S_CHECK) begin
            state <= log_match ? S_REPLY : S_EMPTY;
        end else if (act_rdy) begin
            state <= S_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            reply.reply_type <= act.reply_type;
            reply.view       <= act.view;
            reply.op_num     <= act.op_num;
            reply.replica_id <= act.replica_id;
        end
    end

    assign reply_val = state == S_REPLY;

    reply_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        reply_val && !reply_rdy |=> reply_val && $stable(reply)
    );

endmodule

// ==== rtl/vr_replica_top.sv ====
`timescale 1ns/1ps

module vr_replica_top
    import vr_pkg::*;
#(
    parameter int LOG_DEPTH = 16
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       msg_val,
    input  vr_msg_t    msg,
    output logic       msg_rdy,
    output logic       reply_val,
    output vr_reply_t  reply,
    input  logic       reply_rdy,
    output vr_status_t status
);

    localparam int IDX_W = $clog2(LOG_DEPTH);

    logic             act_val;
    vr_action_t       act;
    logic             act_rdy;
    logic             log_wr_en;
    logic [IDX_W-1:0] log_wr_addr;
    log_hdr_t         log_wr_data;
    logic             log_rd_en;
    logic [IDX_W-1:0] log_rd_addr;
    log_hdr_t         log_rd_data;

    vr_replica_state #(
        .LOG_DEPTH (LOG_DEPTH)
    ) state0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .msg_val     (msg_val),
        .msg         (msg),
        .msg_rdy     (msg_rdy),
        .act_val     (act_val),
        .act         (act),
        .act_rdy     (act_rdy),
        .log_wr_en   (log_wr_en),
        .log_wr_addr (log_wr_addr),
        .log_wr_data (log_wr_data),
        .log_rd_en   (log_rd_en),
        .log_rd_addr (log_rd_addr),
        .status      (status)
    );

    vr_log_hdr_mem #(
        .LOG_DEPTH (LOG_DEPTH)
    ) log_mem0 (
        .clk     (clk),
        .wr_en   (log_wr_en),
        .wr_addr (log_wr_addr),
        .wr_data (log_wr_data),
        .rd_en   (log_rd_en),
        .rd_addr (log_rd_addr),
        .rd_data (log_rd_data)
    );

    vr_reply_gen reply0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .act_val     (act_val),
        .act         (act),
        .act_rdy     (act_rdy),
        .log_rd_data (log_rd_data),
        .reply_val   (reply_val),
        .reply       (reply),
        .reply_rdy   (reply_rdy)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands on a falling edge, away from the flops.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// ==== tests/tb_vr_replica.sv ====
`timescale 1ns/1ps

module tb_vr_replica
    import vr_pkg::*;
;

    localparam int LOG_DEPTH      = 16;
    localparam int IDX_W          = $clog2(LOG_DEPTH);
    localparam int CLK_NS         = 100;
    localparam int MSG_BUDGET     = 200;
    localparam int CYCLES_PER_MSG = 15;
    localparam int WATCHDOG_NS    = MSG_BUDGET * CYCLES_PER_MSG * CLK_NS;

    logic       clk;
    logic       arst_n;
    logic       msg_val = 1'b0;
    vr_msg_t    msg = '0;
    logic       msg_rdy;
    logic       reply_val;
    vr_reply_t  reply;
    logic       reply_rdy = 1'b1;
    vr_status_t status;

    // Reference model of the replica.
    view_num_t   m_view = '0;
    op_num_t     m_last = '0;
    op_num_t     m_commit = '0;
    replica_id_t m_id = '0;
    log_hdr_t    m_log [LOG_DEPTH];
    vr_reply_t   exp_q [$];

    string       test_name = "reset";
    logic        rand_rdy = 1'b0;
    logic [31:0] rdy_lcg = 32'hc3b8;
    logic [31:0] stim_lcg = 32'hc3b8;

    tb_clock #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (4)
    ) clock0 (
        .clk    (clk),
        .arst_n (arst_n)
    );

    vr_replica_top #(
        .LOG_DEPTH (LOG_DEPTH)
    ) dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .msg_val   (msg_val),
        .msg       (msg),
        .msg_rdy   (msg_rdy),
        .reply_val (reply_val),
        .reply     (reply),
        .reply_rdy (reply_rdy),
        .status    (status)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic vr_msg_t make_msg(input logic [1:0] code, input view_num_t view,
                                         input op_num_t op, input op_num_t commit,
                                         input replica_id_t id);
        vr_msg_t m;
        m.msg_type   = vr_msg_type_e'(code);
        m.view       = view;
        m.op_num     = op;
        m.commit_num = commit;
        m.replica_id = id;
        return m;
    endfunction

    function automatic vr_status_t model_status();
        vr_status_t s;
        s.view       = m_view;
        s.commit_num = m_commit;
        return s;
    endfunction

    task automatic push_reply(input vr_reply_type_e kind, input view_num_t view,
                              input op_num_t op, input replica_id_t id);
        vr_reply_t r;
        r.reply_type = kind;
        r.view       = view;
        r.op_num     = op;
        r.replica_id = id;
        exp_q.push_back(r);
    endtask

    task automatic advance_commit(input op_num_t commit, input op_num_t last);
        op_num_t cand;
        cand = (commit < last) ? commit : last;
        if (cand > m_commit) begin
            m_commit = cand;
        end
    endtask

    task automatic apply_model(input vr_msg_t m);
        logic [IDX_W-1:0] slot;
        slot = m.op_num[IDX_W-1:0];
        if (m.msg_type == SETUP) begin
            m_view   = m.view;
            m_last   = m.op_num;
            m_id     = m.replica_id;
            // Commit is capped at the new last op.
            m_commit = (m.commit_num < m.op_num) ? m.commit_num : m.op_num;
            push_reply(SETUP_ACK, m.view, m.op_num, m.replica_id);
        end else if (m.msg_type == PREPARE && m.view == m_view) begin
            if (m.op_num != '0 && m.op_num == m_last + 16'd1) begin
                m_log[slot].view   = m.view;
                m_log[slot].op_num = m.op_num;
                m_last = m.op_num;
                push_reply(PREPARE_OK, m.view, m.op_num, m_id);
            end else if (m.op_num != '0 && m.op_num <= m_last
                         && (m_last - m.op_num) < op_num_t'(LOG_DEPTH)) begin
                if (m_log[slot].view == m.view && m_log[slot].op_num == m.op_num) begin
                    push_reply(PREPARE_OK, m.view, m.op_num, m_id);
                end
            end
            advance_commit(m.commit_num, m_last);
        end else if (m.msg_type == COMMIT && m.view == m_view) begin
            advance_commit(m.commit_num, m_last);
        end
    endtask

    task automatic check_reply(input vr_reply_t exp, input vr_reply_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: reply expected %h actual %h", test_name, exp, act);
            $display("TB FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_status(input vr_status_t exp, input vr_status_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: status expected %h actual %h", test_name, exp, act);
            $display("TB FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Every transfer must match the oldest expected reply.
    always @(posedge clk) begin
        if (arst_n && reply_val && reply_rdy) begin
            if (exp_q.size() == 0) begin
                $display("%s: the DUT sent reply %h when no reply was due", test_name, reply);
                $display("TB FAILED");
                $fatal(1, "unexpected reply");
            end else begin
                check_reply(exp_q.pop_front(), reply);
            end
        end
    end

    always @(negedge clk) begin
        if (rand_rdy) begin
            rdy_lcg   = lcg_next(rdy_lcg);
            reply_rdy = rdy_lcg[24];
        end else begin
            reply_rdy = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired in %s before the tests finished", test_name);
        $display("TB FAILED");
        $fatal(1, "watchdog timeout");
    end

    // Called and returns on a falling edge.
    task automatic send_msg(input vr_msg_t m);
        msg_val = 1'b1;
        msg     = m;
        @(posedge clk);
        while (!msg_rdy) begin
            @(posedge clk);
        end
        apply_model(m);
        @(negedge clk);
        msg_val = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic send_prepare(input view_num_t view, input op_num_t op,
                                input op_num_t commit);
        send_msg(make_msg(2'd1, view, op, commit, '0));
    endtask

    task automatic send_commit(input view_num_t view, input op_num_t commit);
        send_msg(make_msg(2'd2, view, '0, commit, '0));
        check_status(model_status(), status);
    endtask

    task automatic reset_and_setup();
        test_name = "reset_and_setup";
        if (reply_val !== 1'b0) begin
            $display("reply_val is not low after reset");
            $display("TB FAILED");
            $fatal(1, "reply_val after reset");
        end
        check_status('0, status);
        send_msg(make_msg(2'd0, 16'd3, 16'd0, 16'd0, 4'd7));
        check_status(model_status(), status);
        drain();
    endtask

    task automatic prepare_in_order();
        test_name = "prepare_in_order";
        for (int i = 0; i < 10; i++) begin
            send_prepare(m_view, m_last + 16'd1, 16'd0);
        end
        send_prepare(m_view, m_last + 16'd3, 16'd0);
        send_prepare(m_view + 16'd1, m_last + 16'd1, 16'd0);
        send_prepare(m_view, 16'd0, 16'd0);
        send_msg(make_msg(2'd3, m_view, m_last + 16'd1, 16'd0, '0));
        drain();
    endtask

    task automatic commit_advance();
        test_name = "commit_advance";
        send_commit(m_view, 16'd4);
        // A dropped gap prepare still carries a commit.
        send_prepare(m_view, m_last + 16'd20, 16'd7);
        check_status(model_status(), status);
        send_commit(m_view, 16'd2);
        send_commit(m_view + 16'd1, 16'd9);
        send_commit(m_view, 16'd50);
        send_prepare(m_view, m_last + 16'd1, 16'd20);
        check_status(model_status(), status);
        send_prepare(m_view, m_last, 16'd3);
        check_status(model_status(), status);
        drain();
    endtask

    task automatic retransmission();
        op_num_t base;
        test_name = "retransmission";
        for (int i = 0; i < 20; i++) begin
            send_prepare(m_view, m_last + 16'd1, m_commit);
        end
        base = m_last;
        send_prepare(m_view, base - 16'd3, m_commit);
        send_prepare(m_view, base - 16'd15, m_commit);
        send_prepare(m_view, base - 16'd16, m_commit);
        send_prepare(m_view, base - 16'd20, m_commit);
        drain();
        // Slot of op base still holds it, but it is now a full window behind.
        send_msg(make_msg(2'd0, m_view, base + 16'd16, m_commit, m_id));
        send_prepare(m_view, base, m_commit);
        send_msg(make_msg(2'd0, m_view + 16'd1, base, m_commit, m_id));
        send_prepare(m_view, base - 16'd2, m_commit);
        send_prepare(m_view, base + 16'd1, m_commit);
        send_prepare(m_view, base + 16'd1, m_commit);
        drain();
        check_status(model_status(), status);
    endtask

    task automatic back_pressure();
        vr_msg_t m;
        logic [31:0] r;
        test_name = "back_pressure";
        @(posedge clk);
        rand_rdy = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 100; i++) begin
            stim_lcg     = lcg_next(stim_lcg);
            r            = stim_lcg;
            m            = make_msg(2'd1, m_view, m_last + 16'd1, '0, '0);
            m.commit_num = m_last + 16'd2 - op_num_t'(r[19:16]);
            case (r[23:21])
                3'd4: m.op_num = m_last - op_num_t'(r[27:24]);
                3'd5: m.op_num = m_last + 16'd2 + op_num_t'(r[31:28]);
                3'd6: m.op_num = m_last - 16'd16 - op_num_t'(r[31:28]);
                3'd7: m.view = m_view + 16'd1;
                default: m.op_num = m_last + 16'd1;
            endcase
            send_msg(m);
        end
        @(posedge clk);
        rand_rdy = 1'b0;
        @(negedge clk);
        drain();
        check_status(model_status(), status);
    endtask

    initial begin
        @(posedge arst_n);
        @(negedge clk);
        reset_and_setup();
        prepare_in_order();
        commit_advance();
        retransmission();
        back_pressure();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/vr_pkg.sv
rtl/vr_log_hdr_mem.sv
rtl/vr_replica_state.sv
rtl/vr_reply_gen.sv
rtl/vr_replica_top.sv
tests/tb_clock.sv
tests/tb_vr_replica.sv

// ==== Makefile ====
TOP := tb_vr_replica
RTL := rtl/vr_pkg.sv rtl/vr_log_hdr_mem.sv rtl/vr_replica_state.sv \
       rtl/vr_reply_gen.sv rtl/vr_replica_top.sv

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(RTL) tests/tb_clock.sv tests/tb_vr_replica.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --top-module vr_replica_top $(RTL)

clean:
	rm -rf obj_dir
